/* source/fmaPkg.sv */
// Half-precision FMA definitions
package fmaPkg;

    // Default binary16 field widths
    localparam int ExpBits  = 5;
    localparam int FracBits = 10;
    localparam int ExpBias  = 15;

    // Packed operand and result word
    typedef logic [ExpBits+FracBits:0] fpWord;

    // Biased exponent as stored in the word
    typedef logic [ExpBits-1:0] expField;

    // Working exponent with two extra bits
    // Negative values mean underflow and large ones mean overflow
    typedef logic signed [ExpBits+1:0] sumExp;

    // RISC-V frm encoding
    typedef logic [2:0] roundMode;

    localparam roundMode RNE = 3'd0;
    localparam roundMode RTZ = 3'd1;
    localparam roundMode RDN = 3'd2;
    localparam roundMode RUP = 3'd3;
    localparam roundMode RMM = 3'd4;

    // Canonical quiet NaN
    localparam fpWord QNaN = 16'h7E00;

endpackage

/* source/fmaDecode.sv */
// FMA operand decode stage
module fmaDecode #(
    parameter int ExpWidth  = fmaPkg::ExpBits,
    parameter int FracWidth = fmaPkg::FracBits
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  opValid,
    input  fmaPkg::fpWord         x,
    input  fmaPkg::fpWord         y,
    input  fmaPkg::fpWord         z,
    input  logic                  negProd,
    input  logic                  negAdd,
    input  logic                  mulOnly,
    input  logic                  addOnly,
    input  fmaPkg::roundMode      frm,
    output logic                  prodSign,
    output logic                  addSign,
    output logic [ExpWidth-1:0]   xExp,
    output logic [ExpWidth-1:0]   yExp,
    output logic [ExpWidth-1:0]   zExp,
    output logic [FracWidth:0]    xSig,
    output logic [FracWidth:0]    ySig,
    output logic [FracWidth:0]    zSig,
    output logic                  xZero,
    output logic                  yZero,
    output logic                  zZero,
    output logic                  xInf,
    output logic                  yInf,
    output logic                  zInf,
    output logic                  anyNaN,
    output logic                  mulOnlyD,
    output fmaPkg::roundMode      frmD,
    output logic                  validD
);

    localparam int SignPos = ExpWidth + FracWidth;
    localparam logic [ExpWidth-1:0] ExpOnes = '1;
    localparam logic [ExpWidth-1:0] OneExp = ExpWidth'(fmaPkg::ExpBias);
    localparam logic [FracWidth:0] OneSig = {1'b1, {FracWidth{1'b0}}};

    fmaPkg::expField xE, yE, zE;
    logic [FracWidth-1:0] xF, yF, zF;
    logic xZ, yZ, zZ;
    logic xI, yI, zI;
    logic xN, yN, zN;
    logic pSignNext;

    // Field split
    assign xE = x[FracWidth +: ExpWidth];
    assign yE = y[FracWidth +: ExpWidth];
    assign zE = z[FracWidth +: ExpWidth];
    assign xF = x[FracWidth-1:0];
    assign yF = y[FracWidth-1:0];
    assign zF = z[FracWidth-1:0];

    // Zero exponent is a zero here, subnormal fractions are dropped
    assign xZ = (xE == '0);
    assign yZ = (yE == '0);
    assign zZ = (zE == '0);

    // All-ones exponent is infinity or NaN by fraction
    assign xI = (xE == ExpOnes) & (xF == '0);
    assign yI = (yE == ExpOnes) & (yF == '0);
    assign zI = (zE == ExpOnes) & (zF == '0);
    assign xN = (xE == ExpOnes) & (xF != '0);
    assign yN = (yE == ExpOnes) & (yF != '0);
    assign zN = (zE == ExpOnes) & (zF != '0);

    // Add-only forces Y to +1.0 so its sign drops out
    assign pSignNext = x[SignPos] ^ (y[SignPos] & ~addOnly) ^ negProd;

    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= opValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            prodSign <= pSignNext;
            // Multiply-only addend is a zero carrying the product sign
            addSign  <= mulOnly ? pSignNext : (z[SignPos] ^ negAdd);
            xExp     <= xE;
            yExp     <= addOnly ? OneExp : yE;
            zExp     <= mulOnly ? '0 : zE;
            xSig     <= xZ ? '0 : {1'b1, xF};
            ySig     <= addOnly ? OneSig : (yZ ? '0 : {1'b1, yF});
            zSig     <= (mulOnly | zZ) ? '0 : {1'b1, zF};
            xZero    <= xZ;
            yZero    <= yZ & ~addOnly;
            zZero    <= zZ | mulOnly;
            xInf     <= xI;
            yInf     <= yI & ~addOnly;
            zInf     <= zI & ~mulOnly;
            // Replaced operands no longer count as NaN
            anyNaN   <= xN | (yN & ~addOnly) | (zN & ~mulOnly);
            mulOnlyD <= mulOnly;
            frmD     <= frm;
        end
    end

endmodule

/* source/fmaExecute.sv */
// FMA multiply, align and add stage
module fmaExecute #(
    parameter int ExpWidth  = fmaPkg::ExpBits,
    parameter int FracWidth = fmaPkg::FracBits
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  prodSign,
    input  logic                  addSign,
    input  logic [ExpWidth-1:0]   xExp,
    input  logic [ExpWidth-1:0]   yExp,
    input  logic [ExpWidth-1:0]   zExp,
    input  logic [FracWidth:0]    xSig,
    input  logic [FracWidth:0]    ySig,
    input  logic [FracWidth:0]    zSig,
    input  logic                  xZero,
    input  logic                  yZero,
    input  logic                  zZero,
    input  logic                  xInf,
    input  logic                  yInf,
    input  logic                  zInf,
    input  logic                  anyNaN,
    input  logic                  mulOnlyD,
    input  fmaPkg::roundMode      frmD,
    input  logic                  validD,
    output logic [FracWidth+2:0]  sumSig,
    output fmaPkg::sumExp         sumExp,
    output logic                  sumSign,
    output logic                  sumZero,
    output logic                  prodSignE,
    output logic                  addSignE,
    output logic                  infIn,
    output logic                  zInfE,
    output logic                  invalid,
    output logic                  mulOnlyE,
    output fmaPkg::roundMode      frmE,
    output logic                  validE
);

    localparam int SigW   = FracWidth + 1;
    // Carry bit, product, and room below the addend for alignment
    localparam int WinW   = 3 * SigW + 3;
    localparam int ProdSh = WinW - 1 - 2 * SigW;
    localparam int AddSh  = WinW - 2 - SigW;
    localparam int LzW    = $clog2(WinW);
    localparam int ExpW   = $bits(fmaPkg::sumExp);

    logic [2*SigW-1:0] prod;
    fmaPkg::sumExp prodExp, addExp, expDiff, refExp, normExp;
    logic [ExpW-1:0] shiftAmt;
    logic addBig, effSub, diffNeg, shiftSticky;
    logic [WinW-1:0] prodAl, addAl, smallTerm, shifted;
    logic [WinW-1:0] prodTerm, addTerm, mag, norm;
    logic [WinW:0] diff;
    logic [LzW-1:0] lzc;

    ////////////////////////////////////////////////////////////////////////////
    // Product and alignment
    ////////////////////////////////////////////////////////////////////////////

    // Full-width product, binary point two bits below its top
    assign prod    = xSig * ySig;
    assign prodExp = fmaPkg::sumExp'(xExp) + fmaPkg::sumExp'(yExp)
                   - fmaPkg::sumExp'(fmaPkg::ExpBias);
    assign addExp  = fmaPkg::sumExp'(zExp);
    assign expDiff = prodExp - addExp;

    // A zero term always moves, so it never costs the other term precision
    assign addBig = (xZero | yZero) ? 1'b1 : (zZero ? 1'b0 : expDiff[ExpW-1]);
    assign shiftAmt = expDiff[ExpW-1] ? -expDiff : expDiff;
    assign refExp = addBig ? addExp : prodExp;

    // Both terms share one binary point in the window
    assign prodAl = WinW'(prod) << ProdSh;
    assign addAl  = WinW'(zSig) << AddSh;

    // Bits shifted out collapse into the window LSB
    assign smallTerm   = addBig ? prodAl : addAl;
    assign shiftSticky = |(smallTerm & ~({WinW{1'b1}} << shiftAmt));
    assign shifted     = (smallTerm >> shiftAmt) | WinW'(shiftSticky);
    assign prodTerm    = addBig ? shifted : prodAl;
    assign addTerm     = addBig ? addAl : shifted;

    ////////////////////////////////////////////////////////////////////////////
    // Add, magnitude and normalize
    ////////////////////////////////////////////////////////////////////////////

    assign effSub  = prodSign ^ addSign;
    assign diff    = {1'b0, prodTerm} - {1'b0, addTerm};
    assign diffNeg = effSub & diff[WinW];

    always_comb begin
        if (!effSub) begin
            mag = prodTerm + addTerm;
        end else if (diff[WinW]) begin
            mag = addTerm - prodTerm;
        end else begin
            mag = diff[WinW-1:0];
        end
    end

    // Leading zero count, highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < WinW; i++) begin
            if (mag[i]) begin
                lzc = LzW'(WinW - 1 - i);
            end
        end
    end

    assign norm    = mag << lzc;
    // Point sits two below the top, hence the +2
    assign normExp = refExp + fmaPkg::sumExp'(2) - fmaPkg::sumExp'(lzc);

    always_ff @(posedge clk) begin
        if (rst) begin
            validE <= 1'b0;
        end else if (!stall) begin
            validE <= validD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // Significand and guard, then sticky of the rest
            sumSig    <= {norm[WinW-1 -: SigW+1], |norm[WinW-SigW-2:0]};
            // Zero sum gets exponent 0 so it never looks underflowed
            sumExp    <= (mag == '0) ? '0 : normExp;
            sumSign   <= diffNeg ? addSign : prodSign;
            sumZero   <= (mag == '0);
            prodSignE <= prodSign;
            addSignE  <= addSign;
            infIn     <= xInf | yInf | zInf;
            zInfE     <= zInf;
            // NaN in, inf times zero, or inf minus inf
            invalid   <= anyNaN | (xInf & yZero) | (yInf & xZero)
                       | ((xInf | yInf) & zInf & effSub);
            mulOnlyE  <= mulOnlyD;
            frmE      <= frmD;
        end
    end

endmodule

/* source/resultSign.sv */
// FMA result sign
module resultSign (
    input  fmaPkg::roundMode frm,
    input  logic             prodSign,
    input  logic             addSign,
    input  logic             zInf,
    input  logic             infIn,
    input  fmaPkg::sumExp    sumExp,
    input  logic             sumZero,
    input  logic             mulOnly,
    input  logic             roundBit,
    input  logic             stickyBit,
    input  logic             sumSign,
    output logic             sign
);

    localparam int ExpW = $bits(fmaPkg::sumExp);

    logic underflow;
    logic zeroSign;
    logic infSign;

    // Tiny nonzero result that only looks like zero
    assign underflow = sumExp[ExpW-1] | ((sumExp == '0) & (roundBit | stickyBit));

    // Exact cancellation is +0 except in round down
    // Same-sign zeros and multiply-only keep the product sign
    assign zeroSign = ((prodSign ^ addSign) & ~underflow & ~mulOnly)
                    ? (frm == fmaPkg::RDN) : prodSign;

    // Infinite addend decides, otherwise the infinite product
    assign infSign = zInf ? addSign : prodSign;

    assign sign = infIn ? infSign : (sumZero ? zeroSign : sumSign);

endmodule

/* source/fmaResult.sv */
// FMA round and pack stage
module fmaResult #(
    parameter int ExpWidth   = fmaPkg::ExpBits,
    parameter int FracWidth  = fmaPkg::FracBits,
    parameter int NumCredits = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  creditReturn,
    input  logic [FracWidth+2:0]  sumSig,
    input  fmaPkg::sumExp         sumExp,
    input  logic                  sumSign,
    input  logic                  sumZero,
    input  logic                  prodSignE,
    input  logic                  addSignE,
    input  logic                  infIn,
    input  logic                  zInfE,
    input  logic                  invalid,
    input  logic                  mulOnlyE,
    input  fmaPkg::roundMode      frmE,
    input  logic                  validE,
    output logic                  stall,
    output logic                  resultValid,
    output fmaPkg::fpWord         result
);

    localparam int SigW = FracWidth + 1;
    localparam int CntW = $clog2(NumCredits + 1);
    localparam fmaPkg::sumExp ExpTop = fmaPkg::sumExp'((1 << ExpWidth) - 1);

    logic [FracWidth:0] sig;
    logic guardBit, stickyBit, roundUp, carry;
    logic sign, toInf, underflow, overflow;
    logic [SigW:0] rounded;
    fmaPkg::sumExp finalExp;
    fmaPkg::fpWord resWord;
    logic outValid;
    logic [CntW-1:0] credits;

    ////////////////////////////////////////////////////////////////////////////
    // Rounding
    ////////////////////////////////////////////////////////////////////////////

    assign sig       = sumSig[SigW+1:2];
    assign guardBit  = sumSig[1];
    assign stickyBit = sumSig[0];

    // Directed modes look at the sign of the sum
    always_comb begin
        case (frmE)
            fmaPkg::RNE: roundUp = guardBit & (stickyBit | sig[0]);
            fmaPkg::RDN: roundUp = (guardBit | stickyBit) & sumSign;
            fmaPkg::RUP: roundUp = (guardBit | stickyBit) & ~sumSign;
            fmaPkg::RMM: roundUp = guardBit;
            default:     roundUp = 1'b0;
        endcase
    end

    // Carry out leaves an all-zero fraction one binade up
    assign rounded  = {1'b0, sig} + (SigW+1)'(roundUp);
    assign carry    = rounded[SigW];
    assign finalExp = sumExp + fmaPkg::sumExp'(carry);

    assign underflow = finalExp < fmaPkg::sumExp'(1);
    assign overflow  = finalExp >= ExpTop;

    resultSign sign0 (
        .frm       (frmE),
        .prodSign  (prodSignE),
        .addSign   (addSignE),
        .zInf      (zInfE),
        .infIn     (infIn),
        .sumExp    (sumExp),
        .sumZero   (sumZero),
        .mulOnly   (mulOnlyE),
        .roundBit  (guardBit),
        .stickyBit (stickyBit),
        .sumSign   (sumSign),
        .sign      (sign)
    );

    // Overflow goes to infinity unless the mode rounds toward zero for this sign
    always_comb begin
        case (frmE)
            fmaPkg::RTZ: toInf = 1'b0;
            fmaPkg::RDN: toInf = sign;
            fmaPkg::RUP: toInf = ~sign;
            default:     toInf = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Packing, specials first
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (invalid) begin
            resWord = fmaPkg::QNaN;
        end else if (infIn || (overflow && toInf)) begin
            resWord = {sign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}};
        end else if (sumZero || underflow) begin
            resWord = {sign, {(ExpWidth + FracWidth){1'b0}}};
        end else if (overflow) begin
            // Largest finite value
            resWord = {sign, {(ExpWidth-1){1'b1}}, 1'b0, {FracWidth{1'b1}}};
        end else begin
            resWord = {sign, finalExp[ExpWidth-1:0], rounded[FracWidth-1:0]};
        end
    end

    // Held result with no credit freezes the whole pipe
    assign stall       = outValid & (credits == '0);
    assign resultValid = outValid & (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            credits  <= CntW'(NumCredits);
        end else begin
            if (!stall) begin
                outValid <= validE;
            end
            // Return and spend in one cycle cancel
            credits <= credits + CntW'(creditReturn) - CntW'(resultValid);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result <= resWord;
        end
    end

endmodule

/* source/fmaUnit.sv */
// Half-precision FMA unit
module fmaUnit #(
    parameter int ExpWidth   = fmaPkg::ExpBits,
    parameter int FracWidth  = fmaPkg::FracBits,
    parameter int NumCredits = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             opValid,
    output logic             opReady,
    input  fmaPkg::fpWord    x,
    input  fmaPkg::fpWord    y,
    input  fmaPkg::fpWord    z,
    input  logic             negProd,
    input  logic             negAdd,
    input  logic             mulOnly,
    input  logic             addOnly,
    input  fmaPkg::roundMode frm,
    output logic             resultValid,
    output fmaPkg::fpWord    result,
    input  logic             creditReturn
);

    // Common hold for all three stages
    logic stall;

    // Decode to execute
    logic prodSign, addSign;
    logic [ExpWidth-1:0] xExp, yExp, zExp;
    logic [FracWidth:0] xSig, ySig, zSig;
    logic xZero, yZero, zZero;
    logic xInf, yInf, zInf;
    logic anyNaN, mulOnlyD, validD;
    fmaPkg::roundMode frmD;

    // Execute to result
    logic [FracWidth+2:0] sumSig;
    fmaPkg::sumExp sumExp;
    logic sumSign, sumZero, prodSignE, addSignE;
    logic infIn, zInfE, invalid, mulOnlyE, validE;
    fmaPkg::roundMode frmE;

    assign opReady = ~stall;

    fmaDecode #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) decode0 (.*);

    fmaExecute #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) execute0 (.*);

    fmaResult #(
        .ExpWidth   (ExpWidth),
        .FracWidth  (FracWidth),
        .NumCredits (NumCredits)
    ) result0 (.*);

endmodule

/* verif/fmaUnitTb.sv */
// FMA unit testbench
module fmaUnitTb;

    localparam int NumVec     = 41;
    localparam int NumCredits = 2;
    localparam int FillOps    = 6;
    // Three passes with random gaps, held credits and back-to-back issue
    localparam int TotalOps   = 2 * NumVec + FillOps;
    localparam int LimitTime  = (TotalOps * 40 + 200) * 20;

    logic clk;
    logic rst;
    logic opValid;
    logic opReady;
    logic [15:0] x, y, z;
    logic negProd, negAdd, mulOnly, addOnly;
    logic [2:0] frm;
    logic resultValid;
    logic [15:0] result;
    logic creditReturn;

    // Six words per vector in x y z mode frm expected order
    logic [15:0] vecMem [0:6*NumVec-1];

    int edgeCount;
    int errors;
    int failures;
    int resultCount;
    int tbCredits;
    int pendingReturns;
    int waitLeft;
    bit holdCredits;
    bit fastCredits;
    logic [31:0] seed;

    // Outstanding operations in acceptance order
    int expQ[$];
    int edgeQ[$];
    bit latQ[$];

    fmaUnit #(.NumCredits(NumCredits)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .opValid      (opValid),
        .opReady      (opReady),
        .x            (x),
        .y            (y),
        .z            (z),
        .negProd      (negProd),
        .negAdd       (negAdd),
        .mulOnly      (mulOnly),
        .addOnly      (addOnly),
        .frm          (frm),
        .resultValid  (resultValid),
        .result       (result),
        .creditReturn (creditReturn)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    // LCG step returning the better upper bits
    function automatic int unsigned nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[31:16]);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Driver entered and left a short delay after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic driveVector(input int idx, input bit lat);
        logic [15:0] mode;
        bit done;
        begin
            mode    = vecMem[6*idx+3];
            x       = vecMem[6*idx];
            y       = vecMem[6*idx+1];
            z       = vecMem[6*idx+2];
            negProd = mode[3];
            negAdd  = mode[2];
            mulOnly = mode[1];
            addOnly = mode[0];
            frm     = vecMem[6*idx+4][2:0];
            opValid = 1'b1;
            done    = 1'b0;
            while (!done) begin
                // opReady only moves at an edge
                #1;
                if (opReady) begin
                    done = 1'b1;
                    expQ.push_back(idx);
                    edgeQ.push_back(edgeCount + 1);
                    latQ.push_back(lat);
                end
                @(posedge clk);
                #2;
            end
            opValid = 1'b0;
        end
    endtask

    task automatic idleGap(input int cycles);
        begin
            repeat (cycles) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    // Pipe empty and every spent credit handed back
    task automatic waitDrain();
        begin
            while (expQ.size() != 0 || pendingReturns != 0) @(posedge clk);
            #2;
        end
    endtask

    // One credit return pulse per spent credit after a delay
    initial begin
        creditReturn = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            creditReturn = 1'b0;
            if (!holdCredits && pendingReturns > 0) begin
                if (waitLeft == 0) begin
                    creditReturn = 1'b1;
                    pendingReturns--;
                    waitLeft = fastCredits ? 0 : int'(nextRand() % 4);
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checker sampling mid-cycle where outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        int idx;
        int acc;
        bit lat;
        logic [15:0] expected;
        if (!rst && resultValid) begin
            if (tbCredits == 0) begin
                failures++;
                $display("Result delivered at %0t while no credit was outstanding", $time);
            end else begin
                tbCredits--;
            end
            pendingReturns++;
            resultCount++;
            if (expQ.size() == 0) begin
                failures++;
                $display("Result delivered at %0t with no operation outstanding", $time);
            end else begin
                idx = expQ.pop_front();
                acc = edgeQ.pop_front();
                lat = latQ.pop_front();
                expected = vecMem[6*idx+5];
                if (result !== expected) begin
                    errors++;
                    $display("Error at %0t: vector %0d result %h expected %h",
                             $time, idx, result, expected);
                end
                // Taken at the next edge which is three after acceptance
                if (lat && (edgeCount + 1 - acc != 3)) begin
                    errors++;
                    $display("Error at %0t: vector %0d latency %0d expected 3",
                             $time, idx, edgeCount + 1 - acc);
                end
            end
        end
        // Return seen by the DUT at the coming edge
        if (!rst && creditReturn) begin
            tbCredits++;
        end
    end

    // Watchdog
    initial begin
        #(LimitTime);
        $display("Timeout: the run did not finish in time, the pipeline seems stuck");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int startCount;
        rst = 1'b1;
        opValid = 1'b0;
        x = '0;
        y = '0;
        z = '0;
        negProd = 1'b0;
        negAdd = 1'b0;
        mulOnly = 1'b0;
        addOnly = 1'b0;
        frm = '0;
        edgeCount = 0;
        errors = 0;
        failures = 0;
        resultCount = 0;
        tbCredits = NumCredits;
        pendingReturns = 0;
        waitLeft = 0;
        holdCredits = 1'b0;
        fastCredits = 1'b0;
        seed = 32'hd8ec;
        $readmemh("verif/fmaTestdata.txt", vecMem);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Every vector with random idle gaps and slow credits
        for (int i = 0; i < NumVec; i++) begin
            idleGap(int'(nextRand() % 3));
            driveVector(i, 1'b0);
        end
        waitDrain();

        // Credits held back until the pipe is full
        holdCredits = 1'b1;
        startCount = resultCount;
        fork
            begin
                // Last vectors all differ in result so a lost or repeated one shows
                for (int i = 0; i < FillOps; i++) begin
                    driveVector(NumVec - FillOps + i, 1'b0);
                end
            end
            begin
                repeat (12) @(posedge clk);
                #3;
                if (resultCount - startCount != NumCredits) begin
                    failures++;
                    $display("Saw %0d results while credits were held back, expected %0d",
                             resultCount - startCount, NumCredits);
                end
                if (opReady) begin
                    failures++;
                    $display("opReady stayed high with the pipeline full");
                end
                holdCredits = 1'b0;
            end
        join
        waitDrain();

        // Back-to-back with immediate returns and a latency check
        fastCredits = 1'b1;
        waitLeft = 0;
        for (int i = 0; i < NumVec; i++) begin
            driveVector(i, 1'b1);
        end
        waitDrain();
        idleGap(4);

        if (resultCount != TotalOps) begin
            failures++;
            $display("Received %0d results but %0d operations were sent",
                     resultCount, TotalOps);
        end
        $display("Errors: %0d, failures: %0d", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verif/fmaTestdata.txt */
// Columns: x y z mode frm expected, all hex
// mode bits: 3 negProd, 2 negAdd, 1 mulOnly, 0 addOnly
3C00 3C00 3C00 0 0 4000
3E00 3E00 0000 0 0 4080
3C01 3C01 0000 0 0 3C02
3C01 3C01 0000 0 1 3C02
3C01 3C01 0000 0 2 3C02
3C01 3C01 0000 0 3 3C03
3C01 3C01 0000 0 4 3C02
BC01 3C01 0000 0 0 BC02
BC01 3C01 0000 0 1 BC02
BC01 3C01 0000 0 2 BC03
BC01 3C01 0000 0 3 BC02
BC01 3C01 0000 0 4 BC02
3C01 3C00 1000 0 0 3C02
3C01 3C00 1000 0 1 3C01
3C01 3C00 1000 0 4 3C02
3C01 3C01 BC00 0 0 1800
3C01 3C01 BC00 0 3 1801
3C00 3C00 BC00 0 0 0000
3C00 3C00 BC00 0 2 8000
8000 3C00 3C00 2 0 8000
0000 0000 3C00 2 2 0000
0400 0400 0000 0 0 0000
8400 0400 0000 0 0 8000
0000 3C00 8000 0 0 0000
7E00 3C00 3C00 0 0 7E00
7C00 0000 3C00 0 0 7E00
7C00 3C00 FC00 0 0 7E00
3C00 3C00 FC00 0 0 FC00
FC00 3C00 3C00 0 0 FC00
7BFF 4000 0000 0 0 7C00
7BFF 4000 0000 0 1 7BFF
7BFF 4000 0000 0 2 7BFF
7BFF 4000 0000 0 3 7C00
FBFF 4000 0000 0 2 FC00
FBFF 4000 0000 0 3 FBFF
4000 4200 3C00 0 0 4700
4000 4200 3C00 8 0 C500
4000 4200 3C00 4 0 4500
4000 4200 3C00 C 0 C700
4000 4200 3C00 2 0 4600
4000 7E00 3C00 1 0 4200

/* sources.f */
source/fmaPkg.sv
source/fmaDecode.sv
source/fmaExecute.sv
source/resultSign.sv
source/fmaResult.sv
source/fmaUnit.sv
verif/fmaUnitTb.sv

/* runSim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sources.f --top-module fmaUnitTb -o fmaSim &&
out=$(./obj_dir/fmaSim) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
